// File: common/cpu_pkg.sv
package cpu_pkg;

    localparam int WORD_W = 32;
    localparam int REG_ADDR_W = 4;
    localparam int FUNCT_W = 5;

    // instruction field positions
    localparam int OPC_HI = 31;
    localparam int OPC_LO = 29;
    localparam int RS_HI = 28;
    localparam int RS_LO = 25;
    localparam int RT_HI = 24;
    localparam int RT_LO = 21;
    localparam int RD_HI = 20;
    localparam int RD_LO = 17;
    localparam int IMM16_HI = 20;
    localparam int IMM16_LO = 5;
    localparam int IMM23_HI = 24;
    localparam int IMM23_LO = 2;
    localparam int FUNCT_HI = 4;
    localparam int FUNCT_LO = 0;
    localparam int FUNCT2_HI = 1;
    localparam int FUNCT2_LO = 0;

    // bit positions inside funct, and the wait flag of the control instruction
    localparam int IMM_SEL_BIT = 4;
    localparam int STORE_BIT = 0;
    localparam int WAIT_BIT = 28;

    typedef enum logic [2:0] {
        OP_ALU       = 3'd0,
        OP_MEM       = 3'd1,
        OP_BRANCH    = 3'd2,
        OP_STACK     = 3'd3,
        OP_MOVE      = 3'd4,
        OP_CTRL      = 3'd5,
        OP_STACK_ALU = 3'd6,
        OP_TERM      = 3'd7
    } opcode_t;

    // encoding matches funct[2:0] of the ALU instructions
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRA = 3'd6,
        ALU_SRL = 3'd7
    } alu_op_t;

    typedef enum logic [1:0] {
        COND_ALWAYS = 2'd0,
        COND_ZERO   = 2'd1,
        COND_POS    = 2'd2,
        COND_NEG    = 2'd3
    } branch_cond_t;

    typedef enum logic [2:0] {
        ST_FETCH     = 3'd0,
        ST_DECODE    = 3'd1,
        ST_EXECUTE   = 3'd2,
        ST_MEMORY    = 3'd3,
        ST_WRITEBACK = 3'd4,
        ST_TERM      = 3'd5
    } cpu_state_t;

endpackage

// File: control/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
    input  logic [cpu_pkg::WORD_W-1:0]     instr,
    output cpu_pkg::opcode_t               opcode,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rs,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rt,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rd,
    output logic [cpu_pkg::FUNCT_W-1:0]    funct,
    output cpu_pkg::branch_cond_t          cond,
    output logic [cpu_pkg::WORD_W-1:0]     imm16_ext,
    output logic [cpu_pkg::WORD_W-1:0]     imm23_ext,
    output logic                           use_imm,
    output logic                           is_store,
    output logic                           wait_bit
);

    localparam int IMM16_W = cpu_pkg::IMM16_HI - cpu_pkg::IMM16_LO + 1;
    localparam int IMM23_W = cpu_pkg::IMM23_HI - cpu_pkg::IMM23_LO + 1;

    logic [IMM16_W-1:0] imm16;
    logic [IMM23_W-1:0] imm23;

    assign opcode = cpu_pkg::opcode_t'(instr[cpu_pkg::OPC_HI:cpu_pkg::OPC_LO]);

    // register fields overlap the immediates, each consumer picks what it needs
    assign rs = instr[cpu_pkg::RS_HI:cpu_pkg::RS_LO];
    assign rt = instr[cpu_pkg::RT_HI:cpu_pkg::RT_LO];
    assign rd = instr[cpu_pkg::RD_HI:cpu_pkg::RD_LO];

    assign funct = instr[cpu_pkg::FUNCT_HI:cpu_pkg::FUNCT_LO];
    assign cond = cpu_pkg::branch_cond_t'(instr[cpu_pkg::FUNCT2_HI:cpu_pkg::FUNCT2_LO]);

    assign imm16 = instr[cpu_pkg::IMM16_HI:cpu_pkg::IMM16_LO];
    assign imm23 = instr[cpu_pkg::IMM23_HI:cpu_pkg::IMM23_LO];

    // sign extension to the full word
    assign imm16_ext = {{(cpu_pkg::WORD_W - IMM16_W){imm16[IMM16_W-1]}}, imm16};
    assign imm23_ext = {{(cpu_pkg::WORD_W - IMM23_W){imm23[IMM23_W-1]}}, imm23};

    // funct flags: immediate form of ALU ops, store vs load
    assign use_imm = funct[cpu_pkg::IMM_SEL_BIT];
    assign is_store = funct[cpu_pkg::STORE_BIT];

    // program control waits on the halt button only with this bit set
    assign wait_bit = instr[cpu_pkg::WAIT_BIT];

endmodule

// File: control/sequencer.sv
`timescale 1ns/1ps

module sequencer #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 256
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               halt_button,
    output logic [$clog2(IMEM_DEPTH)-1:0]      imem_addr,
    input  logic [cpu_pkg::WORD_W-1:0]         imem_data,
    output logic [cpu_pkg::WORD_W-1:0]         ir,
    input  cpu_pkg::opcode_t                   opcode,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]     rs,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]     rt,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]     rd,
    input  logic [cpu_pkg::FUNCT_W-1:0]        funct,
    input  cpu_pkg::branch_cond_t              cond,
    input  logic [cpu_pkg::WORD_W-1:0]         imm16_ext,
    input  logic [cpu_pkg::WORD_W-1:0]         imm23_ext,
    input  logic                               use_imm,
    input  logic                               is_store,
    input  logic                               wait_bit,
    output logic [cpu_pkg::REG_ADDR_W-1:0]     rf_rd_addr_a,
    output logic [cpu_pkg::REG_ADDR_W-1:0]     rf_rd_addr_b,
    input  logic [cpu_pkg::WORD_W-1:0]         rf_rd_data_a,
    input  logic [cpu_pkg::WORD_W-1:0]         rf_rd_data_b,
    output logic                               rf_wr_en,
    output logic [cpu_pkg::REG_ADDR_W-1:0]     rf_wr_addr,
    output logic [cpu_pkg::WORD_W-1:0]         rf_wr_data,
    output logic [cpu_pkg::WORD_W-1:0]         alu_a,
    output logic [cpu_pkg::WORD_W-1:0]         alu_b,
    output cpu_pkg::alu_op_t                   alu_op,
    input  logic [cpu_pkg::WORD_W-1:0]         alu_result,
    output logic                               dmem_we,
    output logic [$clog2(DMEM_DEPTH)-1:0]      dmem_addr,
    output logic [cpu_pkg::WORD_W-1:0]         dmem_wdata,
    input  logic [cpu_pkg::WORD_W-1:0]         dmem_rdata,
    output logic                               store_valid,
    output logic [$clog2(DMEM_DEPTH)-1:0]      store_addr,
    output logic [cpu_pkg::WORD_W-1:0]         store_data,
    output logic                               retire,
    output logic [cpu_pkg::WORD_W-1:0]         retire_pc,
    output logic                               halted
);

    localparam int IA_W = $clog2(IMEM_DEPTH);
    localparam int DA_W = $clog2(DMEM_DEPTH);

    cpu_pkg::cpu_state_t state;

    logic [cpu_pkg::WORD_W-1:0] pc;
    logic [cpu_pkg::WORD_W-1:0] instr_pc;
    logic [cpu_pkg::WORD_W-1:0] a;
    logic [cpu_pkg::WORD_W-1:0] b;
    logic [cpu_pkg::WORD_W-1:0] alu_out;
    logic [cpu_pkg::WORD_W-1:0] lmd;
    logic                       taken;
    logic                       cond_met;
    logic                       ctrl_wait;
    logic                       is_alu;
    logic                       is_load;

    assign is_alu = (opcode == cpu_pkg::OP_ALU);
    assign is_load = (opcode == cpu_pkg::OP_MEM) && !is_store;
    assign ctrl_wait = (opcode == cpu_pkg::OP_CTRL) && wait_bit && halt_button;

    assign imem_addr = pc[IA_W-1:0];
    assign rf_rd_addr_a = rs;
    assign rf_rd_addr_b = rt;

    // branch test on rs, sampled in decode together with A
    always_comb
    begin
        case (cond)
            cpu_pkg::COND_ALWAYS:
                cond_met = 1'b1;
            cpu_pkg::COND_ZERO:
                cond_met = (rf_rd_data_a == '0);
            cpu_pkg::COND_POS:
                cond_met = !rf_rd_data_a[cpu_pkg::WORD_W-1] && (rf_rd_data_a != '0);
            default:
                cond_met = rf_rd_data_a[cpu_pkg::WORD_W-1];
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= cpu_pkg::ST_FETCH;
            pc <= '0;
            taken <= 1'b0;
        end
        else
        begin
            case (state)
                cpu_pkg::ST_FETCH:
                    state <= cpu_pkg::ST_DECODE;
                cpu_pkg::ST_DECODE:
                begin
                    taken <= (opcode == cpu_pkg::OP_BRANCH) && cond_met;
                    if (opcode == cpu_pkg::OP_TERM)
                        state <= cpu_pkg::ST_TERM;
                    else if (!ctrl_wait)
                        state <= cpu_pkg::ST_EXECUTE;
                end
                cpu_pkg::ST_EXECUTE:
                    state <= cpu_pkg::ST_MEMORY;
                cpu_pkg::ST_MEMORY:
                begin
                    pc <= taken ? alu_out : pc + 1'b1;
                    state <= cpu_pkg::ST_WRITEBACK;
                end
                cpu_pkg::ST_WRITEBACK:
                    state <= cpu_pkg::ST_FETCH;
                cpu_pkg::ST_TERM:
                    state <= cpu_pkg::ST_TERM;
                default:
                    state <= cpu_pkg::ST_FETCH;
            endcase
        end
    end

    // datapath latches, one per state
    always_ff @(posedge clk)
    begin
        if (state == cpu_pkg::ST_FETCH)
        begin
            ir <= imem_data;
            instr_pc <= pc;
        end
        if (state == cpu_pkg::ST_DECODE)
        begin
            a <= rf_rd_data_a;
            b <= rf_rd_data_b;
        end
        if (state == cpu_pkg::ST_EXECUTE)
            alu_out <= alu_result;
        if (state == cpu_pkg::ST_MEMORY && is_load)
            lmd <= dmem_rdata;
    end

    // operand select; moves and no-ops fall through to A plus zero
    always_comb
    begin
        alu_a = a;
        alu_b = '0;
        alu_op = cpu_pkg::ALU_ADD;
        case (opcode)
            cpu_pkg::OP_ALU:
            begin
                alu_b = use_imm ? imm16_ext : b;
                alu_op = cpu_pkg::alu_op_t'(funct[2:0]);
            end
            cpu_pkg::OP_MEM:
                alu_b = imm16_ext;
            cpu_pkg::OP_BRANCH:
            begin
                alu_a = pc;
                alu_b = imm23_ext;
            end
            default:
                alu_b = '0;
        endcase
    end

    assign dmem_we = (state == cpu_pkg::ST_MEMORY) && (opcode == cpu_pkg::OP_MEM) && is_store;
    assign dmem_addr = alu_out[DA_W-1:0];
    assign dmem_wdata = b;

    // register form writes rd, everything else writes rt
    assign rf_wr_en = (state == cpu_pkg::ST_WRITEBACK)
                      && (is_alu || is_load || opcode == cpu_pkg::OP_MOVE);
    assign rf_wr_addr = (is_alu && !use_imm) ? rd : rt;
    assign rf_wr_data = is_load ? lmd : alu_out;

    assign store_valid = dmem_we;
    assign store_addr = dmem_addr;
    assign store_data = b;

    assign retire = (state == cpu_pkg::ST_WRITEBACK);
    assign retire_pc = instr_pc;
    assign halted = (state == cpu_pkg::ST_TERM);

endmodule

// File: run.sh
#!/usr/bin/env bash
# compile with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_cpu -f src.f \
    -Mdir obj_dir -o tb_cpu_sim > build.log 2>&1 \
    && ./obj_dir/tb_cpu_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "TEST PASSED" sim.log && exit 0 || exit 1

// File: source/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [cpu_pkg::WORD_W-1:0] op_a,
    input  logic [cpu_pkg::WORD_W-1:0] op_b,
    input  cpu_pkg::alu_op_t           op,
    output logic [cpu_pkg::WORD_W-1:0] result
);

    logic [4:0] shamt;

    // shifts only look at the low five bits
    assign shamt = op_b[4:0];

    always_comb
    begin
        case (op)
            cpu_pkg::ALU_ADD:
                result = op_a + op_b;
            cpu_pkg::ALU_SUB:
                result = op_a - op_b;
            cpu_pkg::ALU_AND:
                result = op_a & op_b;
            cpu_pkg::ALU_OR:
                result = op_a | op_b;
            cpu_pkg::ALU_XOR:
                result = op_a ^ op_b;
            cpu_pkg::ALU_SLL:
                result = op_a << shamt;
            cpu_pkg::ALU_SRA:
                result = $signed(op_a) >>> shamt;
            cpu_pkg::ALU_SRL:
                result = op_a >> shamt;
            default:
                result = op_a + op_b;
        endcase
    end

endmodule

// File: source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          halt_button,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
    input  logic [cpu_pkg::WORD_W-1:0]    imem_wdata,
    output logic                          store_valid,
    output logic [$clog2(DMEM_DEPTH)-1:0] store_addr,
    output logic [cpu_pkg::WORD_W-1:0]    store_data,
    output logic                          retire,
    output logic [cpu_pkg::WORD_W-1:0]    retire_pc,
    output logic                          halted
);

    logic [$clog2(IMEM_DEPTH)-1:0] fetch_addr;
    logic [cpu_pkg::WORD_W-1:0]    fetch_data;
    logic [cpu_pkg::WORD_W-1:0]    ir;

    // decoded fields
    cpu_pkg::opcode_t               opcode;
    logic [cpu_pkg::REG_ADDR_W-1:0] rs;
    logic [cpu_pkg::REG_ADDR_W-1:0] rt;
    logic [cpu_pkg::REG_ADDR_W-1:0] rd;
    logic [cpu_pkg::FUNCT_W-1:0]    funct;
    cpu_pkg::branch_cond_t          cond;
    logic [cpu_pkg::WORD_W-1:0]     imm16_ext;
    logic [cpu_pkg::WORD_W-1:0]     imm23_ext;
    logic                           use_imm;
    logic                           is_store;
    logic                           wait_bit;

    logic [cpu_pkg::REG_ADDR_W-1:0] rf_rd_addr_a;
    logic [cpu_pkg::REG_ADDR_W-1:0] rf_rd_addr_b;
    logic [cpu_pkg::WORD_W-1:0]     rf_rd_data_a;
    logic [cpu_pkg::WORD_W-1:0]     rf_rd_data_b;
    logic                           rf_wr_en;
    logic [cpu_pkg::REG_ADDR_W-1:0] rf_wr_addr;
    logic [cpu_pkg::WORD_W-1:0]     rf_wr_data;

    logic [cpu_pkg::WORD_W-1:0]     alu_a;
    logic [cpu_pkg::WORD_W-1:0]     alu_b;
    cpu_pkg::alu_op_t               alu_op;
    logic [cpu_pkg::WORD_W-1:0]     alu_result;

    logic                           dmem_we;
    logic [$clog2(DMEM_DEPTH)-1:0]  dmem_addr;
    logic [cpu_pkg::WORD_W-1:0]     dmem_wdata;
    logic [cpu_pkg::WORD_W-1:0]     dmem_rdata;

    // program is written through the top-level port during reset
    word_memory #(.DEPTH(IMEM_DEPTH)) imem_i (
        .clk(clk), .wr_en(imem_we), .wr_addr(imem_addr), .wr_data(imem_wdata),
        .rd_addr(fetch_addr), .rd_data(fetch_data)
    );

    word_memory #(.DEPTH(DMEM_DEPTH)) dmem_i (
        .clk(clk), .wr_en(dmem_we), .wr_addr(dmem_addr), .wr_data(dmem_wdata),
        .rd_addr(dmem_addr), .rd_data(dmem_rdata)
    );

    register_bank register_bank_i (
        .clk(clk), .rst(rst),
        .rd_addr_a(rf_rd_addr_a), .rd_addr_b(rf_rd_addr_b),
        .rd_data_a(rf_rd_data_a), .rd_data_b(rf_rd_data_b),
        .wr_en(rf_wr_en), .wr_addr(rf_wr_addr), .wr_data(rf_wr_data)
    );

    alu alu_i (.op_a(alu_a), .op_b(alu_b), .op(alu_op), .result(alu_result));

    instr_decode instr_decode_i (
        .instr(ir), .opcode(opcode), .rs(rs), .rt(rt), .rd(rd), .funct(funct),
        .cond(cond), .imm16_ext(imm16_ext), .imm23_ext(imm23_ext),
        .use_imm(use_imm), .is_store(is_store), .wait_bit(wait_bit)
    );

    sequencer #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) sequencer_i (
        .clk(clk), .rst(rst), .halt_button(halt_button),
        .imem_addr(fetch_addr), .imem_data(fetch_data), .ir(ir),
        .opcode(opcode), .rs(rs), .rt(rt), .rd(rd), .funct(funct), .cond(cond),
        .imm16_ext(imm16_ext), .imm23_ext(imm23_ext),
        .use_imm(use_imm), .is_store(is_store), .wait_bit(wait_bit),
        .rf_rd_addr_a(rf_rd_addr_a), .rf_rd_addr_b(rf_rd_addr_b),
        .rf_rd_data_a(rf_rd_data_a), .rf_rd_data_b(rf_rd_data_b),
        .rf_wr_en(rf_wr_en), .rf_wr_addr(rf_wr_addr), .rf_wr_data(rf_wr_data),
        .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op), .alu_result(alu_result),
        .dmem_we(dmem_we), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_rdata(dmem_rdata),
        .store_valid(store_valid), .store_addr(store_addr), .store_data(store_data),
        .retire(retire), .retire_pc(retire_pc), .halted(halted)
    );

endmodule

// File: source/register_bank.sv
`timescale 1ns/1ps

module register_bank (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] rd_addr_a,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] rd_addr_b,
    output logic [cpu_pkg::WORD_W-1:0]     rd_data_a,
    output logic [cpu_pkg::WORD_W-1:0]     rd_data_b,
    input  logic                           wr_en,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic [cpu_pkg::WORD_W-1:0]     wr_data
);

    localparam int NUM_REGS = 2 ** cpu_pkg::REG_ADDR_W;

    logic [cpu_pkg::WORD_W-1:0] regs [NUM_REGS];

    // every register is writable, r0 included
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

// File: source/word_memory.sv
`timescale 1ns/1ps

module word_memory #(
    parameter int DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          wr_en,
    input  logic [$clog2(DEPTH)-1:0]      wr_addr,
    input  logic [cpu_pkg::WORD_W-1:0]    wr_data,
    input  logic [$clog2(DEPTH)-1:0]      rd_addr,
    output logic [cpu_pkg::WORD_W-1:0]    rd_data
);

    logic [cpu_pkg::WORD_W-1:0] mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read is combinational, so the fetch state sees the word right away
    assign rd_data = mem[rd_addr];

endmodule

// File: src.f
+incdir+test
common/cpu_pkg.sv
source/alu.sv
source/register_bank.sv
source/word_memory.sv
control/instr_decode.sv
control/sequencer.sv
source/cpu_top.sv
test/tb_cpu.sv

// File: test/cpu_ref_model.svh
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// program image, the last word is the terminate instruction
logic [31:0]     prog [PROG_LEN];
logic [31:0]     m_regs [16];
logic [31:0]     m_dmem [DMEM_DEPTH];

// expected events in program order
logic [31:0]     exp_pc [$];
bit              exp_wait [$];
logic [DA_W-1:0] exp_st_addr [$];
logic [31:0]     exp_st_data [$];

function automatic logic [31:0] alu_model(input logic [2:0] op, input logic [31:0] x,
                                          input logic [31:0] y);
    case (op)
        3'd0: return x + y;
        3'd1: return x - y;
        3'd2: return x & y;
        3'd3: return x | y;
        3'd4: return x ^ y;
        3'd5: return x << y[4:0];
        3'd6: return $signed(x) >>> y[4:0];
        default: return x >> y[4:0];
    endcase
endfunction

function automatic bit branch_taken(input logic [1:0] cond, input logic [31:0] v);
    case (cond)
        2'd0: return 1'b1;
        2'd1: return v == 32'd0;
        2'd2: return !v[31] && (v != 32'd0);
        default: return v[31];
    endcase
endfunction

// r0 is never a destination, so memory ops based on r0 hit words 0 to 31
function automatic void gen_program();
    int         kind;
    logic [3:0] dst;
    for (int i = 0; i < PROG_LEN - 1; i++)
    begin
        kind = rand_below(10);
        dst = 4'(1 + rand_below(15));
        case (kind)
            0, 1: prog[i] = {cpu_pkg::OP_ALU, rand_reg(), rand_reg(), dst, 12'h000, 2'b00,
                             3'(rand_below(8))};
            2, 3: prog[i] = {cpu_pkg::OP_ALU, rand_reg(), dst, 16'(rand_below(65536)), 2'b10,
                             3'(rand_below(8))};
            4: prog[i] = {cpu_pkg::OP_MEM, 4'h0, dst, 16'(rand_below(32)), 5'b00000};
            5, 9: prog[i] = {cpu_pkg::OP_MEM, 4'h0, rand_reg(), 16'(rand_below(32)), 5'b00001};
            // forward only, never past the terminate word
            6: prog[i] = {cpu_pkg::OP_BRANCH, rand_reg(), 23'(1 + rand_below(PROG_LEN - 1 - i)),
                          2'(rand_below(4))};
            7: prog[i] = {cpu_pkg::OP_MOVE, rand_reg(), dst, 21'h0};
            default: prog[i] = {cpu_pkg::OP_CTRL, 1'(rand_below(2)), 28'h0};
        endcase
    end
    prog[PROG_LEN - 1] = {cpu_pkg::OP_TERM, 29'h0};
endfunction

function automatic void run_model();
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] w;
    logic [31:0] a_v;
    logic [31:0] b_v;
    logic [31:0] imm16;
    logic [31:0] imm23;
    logic [31:0] addr;
    logic [2:0]  opc;
    bit          done;
    int          steps;
    pc = '0;
    done = 1'b0;
    steps = 0;
    for (int r = 0; r < 16; r++)
        m_regs[r] = '0;
    for (int k = 0; k < DMEM_DEPTH; k++)
        m_dmem[k] = '0;
    while (!done && steps < 4 * PROG_LEN)
    begin
        w = prog[pc];
        opc = w[31:29];
        a_v = m_regs[w[28:25]];
        b_v = m_regs[w[24:21]];
        imm16 = {{16{w[20]}}, w[20:5]};
        imm23 = {{9{w[24]}}, w[24:2]};
        steps++;
        if (opc == cpu_pkg::OP_TERM)
            done = 1'b1;
        else
        begin
            exp_pc.push_back(pc);
            exp_wait.push_back(opc == cpu_pkg::OP_CTRL && w[28]);
            next_pc = pc + 32'd1;
            case (opc)
                cpu_pkg::OP_ALU:
                    if (w[4])
                        m_regs[w[24:21]] = alu_model(w[2:0], a_v, imm16);
                    else
                        m_regs[w[20:17]] = alu_model(w[2:0], a_v, b_v);
                cpu_pkg::OP_MEM:
                begin
                    addr = (a_v + imm16) % DMEM_DEPTH;
                    if (w[0])
                    begin
                        m_dmem[addr] = b_v;
                        exp_st_addr.push_back(DA_W'(addr));
                        exp_st_data.push_back(b_v);
                    end
                    else
                        m_regs[w[24:21]] = m_dmem[addr];
                end
                cpu_pkg::OP_BRANCH:
                    if (branch_taken(w[1:0], a_v))
                        next_pc = pc + imm23;
                cpu_pkg::OP_MOVE:
                    m_regs[w[24:21]] = a_v;
                default: ;
            endcase
            pc = next_pc;
        end
    end
endfunction

`endif

// File: test/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 256;
    localparam int IA_W = $clog2(IMEM_DEPTH);
    localparam int DA_W = $clog2(DMEM_DEPTH);
    localparam int PROG_LEN = 61;
    localparam int RESET_CYCLES = PROG_LEN + 4;
    localparam int TAIL_CYCLES = 10;
    localparam int HIST_LEN = 4096;

    logic            clk;
    logic            rst;
    logic            halt_button;
    logic            imem_we;
    logic [IA_W-1:0] imem_addr;
    logic [31:0]     imem_wdata;
    logic            store_valid;
    logic [DA_W-1:0] store_addr;
    logic [31:0]     store_data;
    logic            retire;
    logic [31:0]     retire_pc;
    logic            halted;

    logic [31:0] lcg_state;
    int          hb_left;
    logic        hb_level;
    // halt_button level seen by the DUT during each cycle after reset
    bit          hb_hist [HIST_LEN];

    int err_retire;
    int err_store;
    int err_timing;
    int err_other;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // drop the low LCG bits since they repeat quickly
    function automatic int rand_below(input int n);
        logic [31:0] v;
        v = lcg_next();
        return int'(v[31:8] % n);
    endfunction

    function automatic logic [3:0] rand_reg();
        return 4'(rand_below(16));
    endfunction

    `include "cpu_ref_model.svh"

    // alternating stretches of 1 to 6 high cycles and 2 to 12 low cycles
    function automatic logic next_halt_level();
        if (hb_left == 0)
        begin
            hb_level = !hb_level;
            hb_left = hb_level ? 1 + rand_below(6) : 2 + rand_below(11);
        end
        hb_left--;
        return hb_level;
    endfunction

    function automatic int wait_cycles(input int decode_start, input int last);
        int n;
        n = 0;
        while (decode_start + n < last && hb_hist[decode_start + n])
            n++;
        return n;
    endfunction

    cpu_top #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) dut_i (
        .clk(clk), .rst(rst), .halt_button(halt_button),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
        .store_valid(store_valid), .store_addr(store_addr), .store_data(store_data),
        .retire(retire), .retire_pc(retire_pc), .halted(halted)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial
    begin
        int          cycle;
        int          prev_retire;
        int          retire_count;
        int          store_count;
        int          model_retires;
        int          model_stores;
        int          halt_cycle;
        int          hb_total;
        int          extra;
        int          total;
        bit          halt_seen;
        bit          finished;
        bit          wait_flag;
        logic [31:0] exp_value;
        logic [31:0] exp_data;

        rst = 1'b1;
        halt_button = 1'b0;
        imem_we = 1'b0;
        imem_addr = '0;
        imem_wdata = '0;
        lcg_state = 32'd79463;
        hb_left = 0;
        hb_level = 1'b0;
        err_retire = 0;
        err_store = 0;
        err_timing = 0;
        err_other = 0;
        gen_program();
        run_model();
        model_retires = exp_pc.size();
        model_stores = exp_st_addr.size();

        // program goes in while reset is held
        for (int i = 0; i < RESET_CYCLES; i++)
        begin
            @(posedge clk);
            imem_we <= (i < PROG_LEN);
            imem_addr <= IA_W'(i);
            imem_wdata <= (i < PROG_LEN) ? prog[i] : '0;
            rst <= (i < RESET_CYCLES - 1);
            @(negedge clk);
            assert (!retire && !store_valid && !halted) else
            begin
                err_other++;
                $display("outputs active during reset at %0t", $time);
            end
        end

        cycle = 0;
        hb_hist[0] = 1'b0;
        prev_retire = -1;
        retire_count = 0;
        store_count = 0;
        halt_cycle = 0;
        hb_total = 0;
        halt_seen = 1'b0;
        finished = 1'b0;
        while (!finished)
        begin
            @(posedge clk);
            cycle++;
            hb_hist[cycle] = next_halt_level();
            halt_button <= hb_hist[cycle];
            if (hb_hist[cycle])
                hb_total++;
            @(negedge clk);

            if (retire)
            begin
                retire_count++;
                assert (exp_pc.size() > 0) else
                begin
                    err_retire++;
                    $display("retire at %0t after the last expected instruction", $time);
                end
                if (exp_pc.size() > 0)
                begin
                    exp_value = exp_pc.pop_front();
                    wait_flag = exp_wait.pop_front();
                    assert (retire_pc == exp_value) else
                    begin
                        err_retire++;
                        $display("mismatch at %0t: retire_pc got %h expected %h",
                                 $time, retire_pc, exp_value);
                    end
                    // a waiting control instruction sits in decode two cycles after a retire
                    extra = wait_flag ? wait_cycles(prev_retire + 2, cycle) : 0;
                    assert (cycle - prev_retire == 5 + extra) else
                    begin
                        err_timing++;
                        $display("mismatch at %0t: retire gap got %0d expected %0d",
                                 $time, cycle - prev_retire, 5 + extra);
                    end
                end
                prev_retire = cycle;
            end

            if (store_valid)
            begin
                store_count++;
                assert (exp_st_addr.size() > 0) else
                begin
                    err_store++;
                    $display("store at %0t with no store left in the model", $time);
                end
                if (exp_st_addr.size() > 0)
                begin
                    exp_value = 32'(exp_st_addr.pop_front());
                    exp_data = exp_st_data.pop_front();
                    assert (32'(store_addr) == exp_value) else
                    begin
                        err_store++;
                        $display("mismatch at %0t: store_addr got %h expected %h",
                                 $time, store_addr, exp_value);
                    end
                    assert (store_data == exp_data) else
                    begin
                        err_store++;
                        $display("mismatch at %0t: store_data got %h expected %h",
                                 $time, store_data, exp_data);
                    end
                end
            end

            if (halt_seen)
            begin
                assert (halted && !retire) else
                begin
                    err_other++;
                    $display("activity after the machine stopped at %0t", $time);
                end
            end
            else if (halted)
            begin
                halt_seen = 1'b1;
                halt_cycle = cycle;
            end

            if (halt_seen && cycle >= halt_cycle + TAIL_CYCLES)
                finished = 1'b1;
            else if (!halt_seen && cycle >= PROG_LEN * 5 + hb_total + 100)
            begin
                err_other++;
                $display("timeout after %0d cycles without reaching the halted state", cycle);
                finished = 1'b1;
            end
        end

        assert (retire_count == model_retires) else
        begin
            err_retire++;
            $display("mismatch at %0t: retire count got %0d expected %0d",
                     $time, retire_count, model_retires);
        end
        assert (store_count == model_stores) else
        begin
            err_store++;
            $display("mismatch at %0t: store count got %0d expected %0d",
                     $time, store_count, model_stores);
        end

        total = err_retire + err_store + err_timing + err_other;
        $display("errors: retire=%0d store=%0d timing=%0d other=%0d total=%0d",
                 err_retire, err_store, err_timing, err_other, total);
        if (total == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
